// File: hw/motor_cfg_pkg.sv
package motor_cfg_pkg;

	typedef logic [15:0] step_num_t;	// step counts, positions and stroke
	typedef logic [15:0] speed_t;	// one step period in ticks
	typedef logic [8:0]  speed_addr_t;
	typedef logic [2:0]  microstep_t;

	localparam int clk_div_nbr = 8;	// clock cycles per tick
	localparam int motor_nbr = 2;
	localparam int speed_tbl_depth = 2 ** $bits(speed_addr_t);

	// last eight zero-sensor samples, newest in bit 0
	localparam logic [7:0] zpd_seq = 8'b0000_1111;

	typedef enum logic [1:0] {
		idle,
		fetch,	// first table address out
		pulse,
		finish
	} gen_state_t;

endpackage : motor_cfg_pkg

// File: hw/motor_io_pkg.sv
package motor_io_pkg;

	import motor_cfg_pkg::*;

	// one latched move command
	typedef struct packed {
		speed_t     speed;	// table index held at full speed
		step_num_t  step;	// steps in the move
		logic       dir;	// 1 counts position up
		microstep_t ms;
		logic       xen;
		logic       xrst;
	} axis_cmd_t;

	// pins toward the driver chip
	typedef struct packed {
		logic       drive;
		logic       dir;
		microstep_t ms;
		logic       xen;
		logic       xrst;
	} motor_pins_t;

	typedef struct packed {
		logic zpsign;	// stopped on the zero point
		logic tpsign;	// stopped on the stroke end
		logic state;	// move in progress
	} axis_status_t;

endpackage : motor_io_pkg

// File: hw/speed_table.sv
module speed_table import motor_cfg_pkg::*; (
	input  logic        ctl_clk,
	input  logic        resetn,
	input  logic        br_init,
	input  logic        br_wr_en,
	input  speed_t      br_data,
	input  speed_addr_t rd_addr0,
	input  speed_addr_t rd_addr1,
	output speed_t      rd_data0,
	output speed_t      rd_data1
);

	speed_t      mem [speed_tbl_depth];
	speed_addr_t wr_ptr;
	speed_addr_t wr_addr;
	logic        init_d;

	// raising init restarts the load at word 0
	assign wr_addr = (br_init && !init_d) ? '0 : wr_ptr;

	always_ff @(posedge ctl_clk) begin
		if (!resetn) begin
			init_d <= 1'b0;
			wr_ptr <= '0;
		end else begin
			init_d <= br_init;
			if (br_wr_en)
				wr_ptr <= wr_addr + 1'b1;
			else
				wr_ptr <= wr_addr;
		end
	end

	always_ff @(posedge ctl_clk) begin
		if (br_wr_en)
			mem[wr_addr] <= br_data;
		rd_data0 <= mem[rd_addr0];	// one cycle lookup per axis
		rd_data1 <= mem[rd_addr1];
	end

endmodule

// File: hw/axis_regs.sv
module axis_regs import motor_cfg_pkg::*, motor_io_pkg::*; (
	input  logic       ctl_clk,
	input  logic       resetn,
	input  speed_t     s_speed,
	input  step_num_t  s_step,
	input  logic       s_dir,
	input  microstep_t s_ms,
	input  logic       s_xen,
	input  logic       s_xrst,
	input  logic       s_start,
	input  logic       busy,
	output axis_cmd_t  cmd,
	output logic       go
);

	logic       accept;
	speed_t     speed_q;
	step_num_t  step_q;
	logic       dir_q;
	microstep_t ms_q;
	logic       xen_q;
	logic       xrst_q;

	// busy only rises the cycle after go, so go blocks that gap
	assign accept = s_start && !busy && !go;

	always_ff @(posedge ctl_clk) begin
		if (!resetn)
			go <= 1'b0;
		else
			go <= accept;
	end

	always_ff @(posedge ctl_clk) begin
		if (accept) begin
			speed_q <= s_speed;
			step_q <= s_step;
			dir_q <= s_dir;
		end
	end

	// driver settings stay on the pins between moves
	always_ff @(posedge ctl_clk) begin
		if (!resetn) begin
			ms_q <= '0;
			xen_q <= 1'b0;
			xrst_q <= 1'b0;
		end else if (accept) begin
			ms_q <= s_ms;
			xen_q <= s_xen;
			xrst_q <= s_xrst;
		end
	end

	assign cmd = '{speed: speed_q, step: step_q, dir: dir_q, ms: ms_q, xen: xen_q, xrst: xrst_q};

endmodule

// File: hw/step_generator.sv
module step_generator import motor_cfg_pkg::*, motor_io_pkg::*; (
	input  logic         ctl_clk,
	input  logic         resetn,
	input  axis_cmd_t    cmd,
	input  logic         go,
	input  logic         s_stop,
	input  step_num_t    s_stroke,
	input  logic         zpd,
	output speed_addr_t  tbl_addr,
	input  speed_t       tbl_data,
	output motor_pins_t  pins,
	output axis_status_t status
);

	gen_state_t st;
	step_num_t  done_cnt;	// index of the current step
	step_num_t  left_cnt;	// steps left, current one included
	step_num_t  pos;
	speed_t     tick_cnt;
	logic [$clog2(clk_div_nbr)-1:0] div_cnt;
	speed_t     word_q;
	logic       first_q;	// first cycle of the move, word comes straight from the table
	logic       zp_seen;
	logic       zpsign;
	logic       tpsign;
	logic [7:0] zpd_hist;

	speed_t      cur_word;
	logic [31:0] elapsed2;	// twice the cycles spent in this period
	logic [31:0] period;
	logic        rise;
	logic        boundary;
	logic        zp_hit;
	logic        tp_hit;
	logic        end_move;

	// ramp up, hold at the commanded index, ramp down before the end
	function automatic speed_addr_t ramp_idx(step_num_t n, step_num_t rem, speed_t spd);
		step_num_t m;
		m = n;
		if (spd < m)
			m = spd;
		if (rem < m)
			m = rem;
		return m[$bits(speed_addr_t)-1:0];
	endfunction

	// while pulsing, the address runs one step ahead
	assign tbl_addr = (st == pulse) ?
		ramp_idx(done_cnt + 16'd1, left_cnt - 16'd2, cmd.speed) :
		ramp_idx(done_cnt, left_cnt - 16'd1, cmd.speed);

	assign cur_word = first_q ? tbl_data : word_q;
	assign elapsed2 = (32'(tick_cnt) * clk_div_nbr + 32'(div_cnt)) * 2;
	assign period = 32'(cur_word) * clk_div_nbr;
	assign rise = (st == pulse) && (tick_cnt == '0) && (div_cnt == '0);
	assign boundary = (st == pulse) && (tick_cnt == cur_word - 16'd1) &&
		(div_cnt == clk_div_nbr - 1);

	assign zp_hit = !cmd.dir && (zpd_hist == zpd_seq);	// only when heading for zero
	assign tp_hit = cmd.dir && (pos == s_stroke);
	assign end_move = boundary && ((left_cnt == 16'd1) || s_stop || zp_seen || zp_hit || tp_hit);

	always_ff @(posedge ctl_clk) begin
		if (!resetn)
			zpd_hist <= '0;
		else
			zpd_hist <= {zpd_hist[6:0], zpd};
	end

	always_ff @(posedge ctl_clk) begin
		if (first_q || boundary)
			word_q <= tbl_data;
	end

	always_ff @(posedge ctl_clk) begin
		if (!resetn) begin
			st <= idle;
			done_cnt <= '0;
			left_cnt <= '0;
			pos <= '0;
			tick_cnt <= '0;
			div_cnt <= '0;
			first_q <= 1'b0;
			zp_seen <= 1'b0;
			zpsign <= 1'b0;
			tpsign <= 1'b0;
		end else begin
			case (st)
			idle: if (go) begin
				done_cnt <= '0;
				left_cnt <= cmd.step;
				zp_seen <= 1'b0;
				zpsign <= 1'b0;
				tpsign <= 1'b0;
				st <= (cmd.step == '0) ? finish : fetch;	// empty move never raises state
			end
			fetch: begin
				tick_cnt <= '0;
				div_cnt <= '0;
				first_q <= 1'b1;
				st <= pulse;
			end
			pulse: begin
				first_q <= 1'b0;
				if (zp_hit)
					zp_seen <= 1'b1;
				if (rise)
					pos <= cmd.dir ? pos + 16'd1 : pos - 16'd1;
				if (boundary) begin
					tick_cnt <= '0;
					div_cnt <= '0;
					done_cnt <= done_cnt + 16'd1;
					left_cnt <= left_cnt - 16'd1;
					if (end_move)
						st <= finish;
					if (zp_seen || zp_hit) begin
						pos <= '0;
						zpsign <= 1'b1;
					end
					if (tp_hit)
						tpsign <= 1'b1;
				end else if (div_cnt == clk_div_nbr - 1) begin
					div_cnt <= '0;
					tick_cnt <= tick_cnt + 16'd1;
				end else begin
					div_cnt <= div_cnt + 1'b1;
				end
			end
			finish: st <= idle;	// state already low here
			default: st <= idle;
			endcase
		end
	end

	assign pins.drive = (st == pulse) && (elapsed2 < period);	// high for the first half
	assign pins.dir = cmd.dir;
	assign pins.ms = cmd.ms;
	assign pins.xen = cmd.xen;
	assign pins.xrst = cmd.xrst;

	assign status.zpsign = zpsign;
	assign status.tpsign = tpsign;
	assign status.state = (st == fetch) || (st == pulse);

endmodule

// File: hw/step_motor.sv
module step_motor import motor_cfg_pkg::*, motor_io_pkg::*; (
	input  logic         ctl_clk,
	input  logic         resetn,
	input  logic         br_init,
	input  logic         br_wr_en,
	input  speed_t       br_data,
	input  logic         m_zpd    [motor_nbr],
	output motor_pins_t  m_pins   [motor_nbr],
	input  step_num_t    s_stroke [motor_nbr],
	input  speed_t       s_speed  [motor_nbr],
	input  step_num_t    s_step   [motor_nbr],
	input  logic         s_start  [motor_nbr],
	input  logic         s_stop   [motor_nbr],
	input  logic         s_dir    [motor_nbr],
	input  microstep_t   s_ms     [motor_nbr],
	input  logic         s_xen    [motor_nbr],
	input  logic         s_xrst   [motor_nbr],
	output axis_status_t s_status [motor_nbr]
);

	axis_cmd_t   cmd      [motor_nbr];
	logic        go       [motor_nbr];
	speed_addr_t tbl_addr [motor_nbr];
	speed_t      tbl_data [motor_nbr];

	// one read port per axis
	speed_table tbl_i (
		.ctl_clk  (ctl_clk),
		.resetn   (resetn),
		.br_init  (br_init),
		.br_wr_en (br_wr_en),
		.br_data  (br_data),
		.rd_addr0 (tbl_addr[0]),
		.rd_addr1 (tbl_addr[1]),
		.rd_data0 (tbl_data[0]),
		.rd_data1 (tbl_data[1])
	);

	for (genvar i = 0; i < motor_nbr; i++) begin : g_axis
		axis_regs regs_i (
			.ctl_clk (ctl_clk),
			.resetn  (resetn),
			.s_speed (s_speed[i]),
			.s_step  (s_step[i]),
			.s_dir   (s_dir[i]),
			.s_ms    (s_ms[i]),
			.s_xen   (s_xen[i]),
			.s_xrst  (s_xrst[i]),
			.s_start (s_start[i]),
			.busy    (s_status[i].state),
			.cmd     (cmd[i]),
			.go      (go[i])
		);

		step_generator gen_i (
			.ctl_clk  (ctl_clk),
			.resetn   (resetn),
			.cmd      (cmd[i]),
			.go       (go[i]),
			.s_stop   (s_stop[i]),
			.s_stroke (s_stroke[i]),
			.zpd      (m_zpd[i]),
			.tbl_addr (tbl_addr[i]),
			.tbl_data (tbl_data[i]),
			.pins     (m_pins[i]),
			.status   (s_status[i])
		);
	end

endmodule

// File: testbench/tb_axis_model.svh
`ifndef TB_AXIS_MODEL_SVH
`define TB_AXIS_MODEL_SVH

speed_t       tbl_model  [speed_tbl_depth];
step_num_t    pos_model  [motor_nbr];
axis_status_t sign_model [motor_nbr];	// signs after the last move
speed_t       exp_period [$];	// cycles per step of the running move

// ramp up by one index per step, hold at spd, ramp down into the last step
function automatic int ramp_step(int k, int n, int spd);
	int idx;
	idx = k;
	if (spd < idx)
		idx = spd;
	if (n - 1 - k < idx)
		idx = n - 1 - k;
	return idx;
endfunction

// fills exp_period, moves the position model and returns the move length in cycles
function automatic int predict_move(int ax, int steps, logic dir, int spd,
		step_num_t stroke, int cut, logic zero);
	int n;
	int k;
	int total;
	step_num_t gap;
	n = steps;
	if (cut >= 0 && cut + 1 < n)
		n = cut + 1;	// stop or zero sensor ends it after step cut
	gap = stroke - pos_model[ax];
	sign_model[ax] = '0;
	if (dir && gap != 0 && int'(gap) <= n) begin
		n = int'(gap);
		sign_model[ax].tpsign = 1'b1;
	end
	exp_period.delete();
	total = 0;
	for (k = 0; k < n; k++) begin
		exp_period.push_back(speed_t'(int'(tbl_model[ramp_step(k, steps, spd)]) * clk_div_nbr));
		total += int'(exp_period[k]);
	end
	if (zero) begin
		pos_model[ax] = '0;
		sign_model[ax].zpsign = 1'b1;
	end else if (dir)
		pos_model[ax] = pos_model[ax] + step_num_t'(n);
	else
		pos_model[ax] = pos_model[ax] - step_num_t'(n);
	return total;
endfunction

`endif

// File: testbench/tb_step_motor.sv
module tb_step_motor import motor_cfg_pkg::*, motor_io_pkg::*;;

	logic         ctl_clk;
	logic         resetn;
	logic         br_init;
	logic         br_wr_en;
	speed_t       br_data;
	logic         m_zpd    [motor_nbr];
	motor_pins_t  m_pins   [motor_nbr];
	step_num_t    s_stroke [motor_nbr];
	speed_t       s_speed  [motor_nbr];
	step_num_t    s_step   [motor_nbr];
	logic         s_start  [motor_nbr];
	logic         s_stop   [motor_nbr];
	logic         s_dir    [motor_nbr];
	microstep_t   s_ms     [motor_nbr];
	logic         s_xen    [motor_nbr];
	logic         s_xrst   [motor_nbr];
	axis_status_t s_status [motor_nbr];

	logic [31:0] seed;
	int          err_cnt;
	int          check_cnt;
	int          cycle_cnt;
	int          cycle_limit;

	`include "tb_axis_model.svh"

	step_motor dut_i (.*);

	initial begin
		ctl_clk = 1'b0;
		forever #2 ctl_clk = ~ctl_clk;
	end

	always @(posedge ctl_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt > cycle_limit) begin
			$display("timeout after %0d cycles, a move never finished", cycle_cnt);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	function automatic int rand_below(int n);
		seed = seed * 32'd1664525 + 32'd1013904223;
		return int'(seed[30:8]) % n;	// low bits of an LCG repeat too soon
	endfunction

	task automatic check_pins(int ax, motor_pins_t exp);
		check_cnt++;
		if (m_pins[ax] !== exp) begin
			err_cnt++;
			$display("ERR %0t axis %0d pins %b, expected %b", $time, ax, m_pins[ax], exp);
		end
	endtask

	task automatic check_status(int ax, axis_status_t exp);
		check_cnt++;
		if (s_status[ax] !== exp) begin
			err_cnt++;
			$display("ERR %0t axis %0d status %b, expected %b", $time, ax, s_status[ax], exp);
		end
	endtask

	task automatic check_period(int ax, int k, speed_t exp, speed_t got);
		check_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("ERR %0t axis %0d step %0d lasts %0d cycles, expected %0d",
				$time, ax, k, got, exp);
		end
	endtask

	// the first two words are written while init is still high
	task automatic load_table();
		int a;
		for (a = 0; a < speed_tbl_depth; a++) begin
			@(negedge ctl_clk);
			br_init = (a < 2);
			br_wr_en = 1'b1;
			br_data = speed_t'(1 + rand_below(8));
			tbl_model[a] = br_data;
		end
		@(negedge ctl_clk);
		br_init = 1'b0;
		br_wr_en = 1'b0;
	endtask

	task automatic close_step(int ax, int k, int len, int hi);
		speed_t exp;
		if (exp_period.size() == 0) begin
			err_cnt++;
			$display("axis %0d made step %0d, more steps than expected", ax, k);
		end else begin
			exp = exp_period.pop_front();
			check_period(ax, k, exp, speed_t'(len));
			check_period(ax, k, exp / 2, speed_t'(hi));	// drive high time
		end
	endtask

	// kind 0 plain, 1 stop, 2 zero sensor, 3 stroke end
	task automatic run_move(int ax, int kind);
		int steps;
		int spd;
		int cut;
		int rises;
		int len;
		int hi;
		logic dir;
		logic prev;
		step_num_t stroke;
		motor_pins_t pins_exp;
		axis_status_t busy_exp;
		steps = 1 + rand_below(40);
		spd = rand_below(24);
		cut = (kind == 1 || kind == 2) ? rand_below(steps) : -1;
		dir = (kind == 2) ? 1'b0 : (kind == 3) ? 1'b1 : 1'(rand_below(2));
		stroke = pos_model[ax] + step_num_t'((kind == 3) ? 1 + rand_below(steps) : steps + 5);
		pins_exp.drive = 1'b0;
		pins_exp.dir = dir;
		pins_exp.ms = microstep_t'(rand_below(8));
		pins_exp.xen = 1'(rand_below(2));
		pins_exp.xrst = 1'(rand_below(2));
		cycle_limit += predict_move(ax, steps, dir, spd, stroke, cut, kind == 2) + 64;
		@(negedge ctl_clk);
		s_speed[ax] = speed_t'(spd);
		s_step[ax] = step_num_t'(steps);
		s_stroke[ax] = stroke;
		s_dir[ax] = dir;
		s_ms[ax] = pins_exp.ms;
		s_xen[ax] = pins_exp.xen;
		s_xrst[ax] = pins_exp.xrst;
		s_start[ax] = 1'b1;
		@(negedge ctl_clk);
		s_start[ax] = 1'b0;
		while (!s_status[ax].state)
			@(negedge ctl_clk);
		busy_exp = '0;
		busy_exp.state = 1'b1;
		check_status(ax, busy_exp);
		check_pins(ax, pins_exp);
		s_start[ax] = 1'b1;	// must be ignored while busy
		s_dir[ax] = !dir;
		s_ms[ax] = ~pins_exp.ms;
		s_xen[ax] = !pins_exp.xen;
		s_xrst[ax] = !pins_exp.xrst;
		s_step[ax] = 16'd1;
		rises = 0;
		len = 0;
		hi = 0;
		prev = 1'b0;
		@(negedge ctl_clk);
		s_start[ax] = 1'b0;
		while (s_status[ax].state) begin
			if (m_pins[ax].drive && !prev) begin
				if (rises > 0)
					close_step(ax, rises - 1, len, hi);
				if (rises == cut) begin
					s_stop[ax] = (kind == 1);
					m_zpd[ax] = (kind == 2);	// four zeros then ones
				end
				rises++;
				len = 0;
				hi = 0;
			end
			prev = m_pins[ax].drive;
			len++;
			if (prev)
				hi++;
			@(negedge ctl_clk);
		end
		if (rises > 0)
			close_step(ax, rises - 1, len, hi);
		if (exp_period.size() != 0) begin
			err_cnt++;
			$display("axis %0d stopped after %0d steps, %0d more were expected",
				ax, rises, exp_period.size());
		end
		s_stop[ax] = 1'b0;
		m_zpd[ax] = 1'b0;
		check_status(ax, sign_model[ax]);
		check_pins(ax, pins_exp);
		repeat (10) @(negedge ctl_clk);	// lets the zero history fill with zeros
	endtask

	initial begin
		int i;
		seed = 32'h26c44754;
		err_cnt = 0;
		check_cnt = 0;
		cycle_cnt = 0;
		cycle_limit = 10 + 2 * (speed_tbl_depth + 4) + 64;	// reset and two table loads
		resetn = 1'b0;
		br_init = 1'b0;
		br_wr_en = 1'b0;
		br_data = '0;
		for (i = 0; i < motor_nbr; i++) begin
			m_zpd[i] = 1'b0;
			s_stroke[i] = '0;
			s_speed[i] = '0;
			s_step[i] = '0;
			s_start[i] = 1'b0;
			s_stop[i] = 1'b0;
			s_dir[i] = 1'b0;
			s_ms[i] = '0;
			s_xen[i] = 1'b0;
			s_xrst[i] = 1'b0;
			pos_model[i] = '0;
			sign_model[i] = '0;
		end
		repeat (10) @(negedge ctl_clk);
		resetn = 1'b1;
		for (i = 0; i < motor_nbr; i++)
			check_status(i, '0);
		load_table();
		// groups of four moves per axis so a stroke move follows each zero move
		for (i = 0; i < 24; i++) begin
			if (i == 12)
				load_table();
			run_move((i >> 2) & 1, i % 4);
		end
		$display("%0d checks, %0d errors", check_cnt, err_cnt);
		if (err_cnt == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// File: src.f
+incdir+testbench
hw/motor_cfg_pkg.sv
hw/motor_io_pkg.sv
hw/speed_table.sv
hw/axis_regs.sv
hw/step_generator.sv
hw/step_motor.sv
testbench/tb_step_motor.sv

// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal -f src.f --top-module tb_step_motor \
		-Mdir obj_dir -o sim
	./obj_dir/sim > $(LOG)
	@cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
